// ==== rtl/spi_slave_pkg.sv ====
/*
 * SPI slave endpoint package
 * Word format, bus clock mode, default response word and the shared
 * types used by the receive path and the frame state machine
 */
package spi_slave_pkg;

  // ******************************
  // Word format
  // ******************************

  // Bits per SPI word, shifted MSB first in both directions
  localparam int SPI_WORD_W = 16;

  typedef logic [SPI_WORD_W-1:0] word_t;

  // Wide enough to hold any count from 0 up to SPI_WORD_W
  localparam int BIT_CNT_W = $clog2(SPI_WORD_W + 1);

  // ******************************
  // Bus clock mode
  // ******************************

  // Idle level of sclk
  localparam bit SPI_CPOL = 1'b0;
  // 0 samples on the leading edge, 1 samples on the trailing edge
  localparam bit SPI_CPHA = 1'b0;

  // Response shifted out when the local side loaded nothing
  localparam word_t SPI_DEFAULT_MISO = word_t'('hCAFE);

  // Flops in each pin synchronizer
  localparam int SPI_SYNC_STAGES = 2;

  // ******************************
  // Shared types
  // ******************************

  // One received word plus the first-in-frame marker
  typedef struct packed {
    word_t data;
    logic  first;
  } rx_entry_t;

  // Frame tracking states
  // GAP sits between a finished word and the first bit of the next one
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    SHIFT = 2'd1,
    GAP   = 2'd2
  } frame_state_t;

endpackage

// ==== rtl/spi_pin_sync.sv ====
/*
 * SPI pin synchronizer
 * Brings sclk, cs_n and mosi into the clk domain and turns the bus edges
 * into single-cycle sample, shift and frame strobes
 */
`timescale 1ns/10ps

module spi_pin_sync import spi_slave_pkg::*; (
  input  logic clk,
  input  logic arst_n,
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic sample_stb,
  output logic shift_stb,
  output logic frame_start,
  output logic frame_end,
  output logic mosi_s,
  // Chip select level, aligned with the frame strobes
  output logic cs_active
);

  logic [SPI_SYNC_STAGES-1:0] sclk_sync;
  logic [SPI_SYNC_STAGES-1:0] cs_sync;
  logic [SPI_SYNC_STAGES-1:0] mosi_sync;
  logic                       sclk_d;
  logic                       cs_d;
  logic                       sclk_s;
  logic                       cs_s;
  logic                       sclk_rise;
  logic                       sclk_fall;
  logic                       sample_edge;
  logic                       shift_edge;

  // Last synchronizer stage of each pin
  assign sclk_s = sclk_sync[SPI_SYNC_STAGES-1];
  assign cs_s   = cs_sync[SPI_SYNC_STAGES-1];

  assign sclk_rise = sclk_s & ~sclk_d;
  assign sclk_fall = ~sclk_s & sclk_d;

  // Sampling happens on the rising edge when CPOL and CPHA agree
  // The shift edge is always the other one
  assign sample_edge = (SPI_CPOL == SPI_CPHA) ? sclk_rise : sclk_fall;
  assign shift_edge  = (SPI_CPOL == SPI_CPHA) ? sclk_fall : sclk_rise;

  // ******************************
  // Synchronizers and strobes
  // ******************************

  // Strobes are registered once more, so a pin edge shows up on them
  // SPI_SYNC_STAGES plus one cycles later
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // sclk starts at its idle level so no false edge follows reset
      sclk_sync   <= {SPI_SYNC_STAGES{SPI_CPOL}};
      cs_sync     <= '1;
      mosi_sync   <= '0;
      sclk_d      <= SPI_CPOL;
      cs_d        <= 1'b1;
      sample_stb  <= 1'b0;
      shift_stb   <= 1'b0;
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
      mosi_s      <= 1'b0;
      cs_active   <= 1'b0;
    end else begin
      sclk_sync   <= {sclk_sync[SPI_SYNC_STAGES-2:0], sclk};
      cs_sync     <= {cs_sync[SPI_SYNC_STAGES-2:0], cs_n};
      mosi_sync   <= {mosi_sync[SPI_SYNC_STAGES-2:0], mosi};
      sclk_d      <= sclk_s;
      cs_d        <= cs_s;
      // Edges on sclk count only while the slave is selected
      sample_stb  <= sample_edge & ~cs_s;
      shift_stb   <= shift_edge & ~cs_s;
      frame_start <= cs_d & ~cs_s;
      frame_end   <= ~cs_d & cs_s;
      // mosi gets the same extra stage as the strobes
      mosi_s      <= mosi_sync[SPI_SYNC_STAGES-1];
      cs_active   <= ~cs_s;
    end
  end

  // A frame never closes on the cycle right after it opens
  assert property (@(posedge clk) disable iff (!arst_n) frame_start |=> !frame_end);

endmodule

// ==== rtl/spi_bit_counter.sv ====
/*
 * SPI bit counter
 * Counts sampled bits inside a word and flags the last one
 */
`timescale 1ns/10ps

module spi_bit_counter import spi_slave_pkg::*; (
  input  logic clk,
  input  logic arst_n,
  input  logic sample_stb,
  input  logic clear,
  output logic last_bit
);

  logic [BIT_CNT_W-1:0] cnt_q;

  // Bits already taken in the current word
  // The next sample completes the word when this is set
  assign last_bit = (cnt_q == BIT_CNT_W'(SPI_WORD_W - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= '0;
    end else if (clear) begin
      // Frame boundaries restart the count
      cnt_q <= '0;
    end else if (sample_stb) begin
      // Wrap straight back to zero after the last bit of a word
      if (last_bit) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // The count stays inside one word
  assert property (@(posedge clk) disable iff (!arst_n)
    cnt_q <= BIT_CNT_W'(SPI_WORD_W - 1));

endmodule

// ==== rtl/spi_frame_fsm.sv ====
/*
 * SPI frame state machine
 * Follows the chip select frame, marks completed words and the first word
 * of each frame, and schedules the response loads
 */
`timescale 1ns/10ps

module spi_frame_fsm import spi_slave_pkg::*; (
  input  logic clk,
  input  logic arst_n,
  input  logic frame_start,
  input  logic frame_end,
  input  logic sample_stb,
  input  logic last_bit,
  output logic cnt_clear,
  output logic load_tx,
  output logic word_done,
  output logic first_word,
  output logic discard
);

  frame_state_t state_q;
  frame_state_t state_d;
  logic         first_q;

  // ******************************
  // Next state
  // ******************************

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (frame_start) begin
          state_d = SHIFT;
        end
      end
      SHIFT: begin
        // cs going away here leaves a partial word behind
        if (frame_end) begin
          state_d = IDLE;
        end else if (sample_stb && last_bit) begin
          state_d = GAP;
        end
      end
      GAP: begin
        // The next sample is already bit one of the following word
        if (frame_end) begin
          state_d = IDLE;
        end else if (sample_stb) begin
          state_d = SHIFT;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Partial word thrown away when cs rises inside SHIFT
  assign discard = frame_end && (state_q == SHIFT);

  // Counter restarts at a new frame and after a dropped partial word
  assign cnt_clear = frame_start | discard;

  // Response word is pulled at frame start and at each word boundary
  assign load_tx = frame_start | word_done;

  // Holds until the first word of the frame completes
  assign first_word = first_q;

  // ******************************
  // State and flags
  // ******************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= IDLE;
      word_done <= 1'b0;
      first_q   <= 1'b0;
    end else begin
      state_q   <= state_d;
      // Pulses one cycle after the sample that took the last bit
      word_done <= (state_q == SHIFT) && sample_stb && last_bit;
      if (frame_start) begin
        first_q <= 1'b1;
      end else if (word_done || frame_end) begin
        first_q <= 1'b0;
      end
    end
  end

endmodule

// ==== rtl/spi_shift_reg.sv ====
/*
 * SPI shift registers
 * Captures MOSI into the receive word and shifts the response word out on MISO
 */
`timescale 1ns/10ps

module spi_shift_reg import spi_slave_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  sample_stb,
  input  logic  shift_stb,
  input  logic  mosi_s,
  input  logic  load_tx,
  input  logic  tx_valid,
  input  word_t tx_word,
  input  logic  cs_active,
  output word_t rx_word,
  output logic  miso
);

  word_t tx_sr;
  word_t tx_next;
  logic  miso_q;
  logic  cs_q;
  logic  frame_load;

  // Receive side, MSB arrives first
  always_ff @(posedge clk) begin
    if (sample_stb) begin
      rx_word <= {rx_word[SPI_WORD_W-2:0], mosi_s};
    end
  end

  // Response for the coming word
  assign tx_next = tx_valid ? tx_word : SPI_DEFAULT_MISO;

  // A load while cs was inactive last cycle is the one at frame start
  assign frame_load = load_tx & ~cs_q;

  // ******************************
  // Transmit side
  // ******************************

  // Each shift moves the next bit from tx_sr into miso_q
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_sr  <= '0;
      miso_q <= 1'b0;
      cs_q   <= 1'b0;
    end else begin
      cs_q <= cs_active;
      if (load_tx) begin
        if (frame_load && !SPI_CPHA) begin
          // With CPHA 0 no shift edge comes before the first sample
          // so bit one goes out straight away
          miso_q <= tx_next[SPI_WORD_W-1];
          tx_sr  <= {tx_next[SPI_WORD_W-2:0], 1'b0};
        end else begin
          // Next shift edge presents the MSB
          tx_sr <= tx_next;
        end
      end else if (shift_stb) begin
        miso_q <= tx_sr[SPI_WORD_W-1];
        tx_sr  <= {tx_sr[SPI_WORD_W-2:0], 1'b0};
      end
    end
  end

  // Pin sits low whenever the slave is not selected
  assign miso = cs_active & miso_q;

  // Loads land between bus edges, never on top of a shift
  assert property (@(posedge clk) disable iff (!arst_n) !(load_tx && shift_stb));

endmodule

// ==== rtl/spi_word_hold.sv ====
/*
 * Single-entry word holding register
 * Four-phase req/ack on the local side, either as the requesting source
 * or as the answering sink, with overrun detection on the write side
 */
`timescale 1ns/10ps

module spi_word_hold #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     arst_n,
  // 1 when this block raises the request, 0 when it answers one
  input  logic     role_is_source,
  input  logic     wr_stb,
  input  payload_t wr_data,
  input  logic     rd_stb,
  // Line driven by this block, the request as source and the answer as sink
  output logic     req,
  // Line watched by this block, the answer as source and the request as sink
  input  logic     ack,
  output payload_t data,
  output logic     full,
  output logic     overrun
);

  logic full_q;
  logic line_q;
  logic done_q;
  logic take;

  // Source takes from the write strobe, sink from the far side's request
  // A sink keeps the far side waiting while a word is still unconsumed
  always_comb begin
    if (role_is_source) begin
      take = wr_stb & ~full_q;
    end else begin
      take = ack & ~full_q & ~line_q;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      data <= wr_data;
    end
  end

  // ******************************
  // Handshake control
  // ******************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full_q  <= 1'b0;
      line_q  <= 1'b0;
      done_q  <= 1'b0;
      overrun <= 1'b0;
    end else if (role_is_source) begin
      if (take) begin
        full_q <= 1'b1;
        line_q <= 1'b1;
      end else if (line_q && ack) begin
        line_q <= 1'b0;
        done_q <= 1'b1;
      end else if (done_q && !ack) begin
        // Entry is free once ack falls
        done_q <= 1'b0;
        full_q <= 1'b0;
      end
      // A write that finds the entry busy is lost for good
      if (wr_stb && full_q) begin
        overrun <= 1'b1;
      end
    end else begin
      if (take) begin
        full_q <= 1'b1;
        line_q <= 1'b1;
      end else begin
        if (line_q && !ack) begin
          line_q <= 1'b0;
        end
        if (full_q && rd_stb) begin
          full_q <= 1'b0;
        end
      end
    end
  end

  assign req  = line_q;
  assign full = full_q;

  // Held payload does not move until the entry is released
  assert property (@(posedge clk) disable iff (!arst_n)
    full_q && $past(full_q) |-> $stable(data));

endmodule

// ==== rtl/spi_slave_top.sv ====
/*
 * SPI slave endpoint
 * Oversampled SPI slave with a four-phase receive handshake and a
 * four-phase response load handshake on the local side
 */
`timescale 1ns/10ps

module spi_slave_top import spi_slave_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  sclk,
  input  logic  cs_n,
  input  logic  mosi,
  output logic  miso,
  output word_t rx_data,
  output logic  rx_first,
  output logic  rx_req,
  input  logic  rx_ack,
  input  word_t tx_data,
  input  logic  tx_req,
  output logic  tx_ack,
  output logic  overrun
);

  // ******************************
  // Internal nets
  // ******************************

  logic  sample_stb;
  logic  shift_stb;
  logic  frame_start;
  logic  frame_end;
  logic  mosi_s;
  logic  cs_active;
  logic  last_bit;
  logic  cnt_clear;
  logic  load_tx;
  logic  word_done;
  logic  first_word;
  word_t rx_word;
  word_t tx_held;
  logic  tx_valid;

  spi_pin_sync i_pin_sync (
    .clk         (clk),
    .arst_n      (arst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .sample_stb  (sample_stb),
    .shift_stb   (shift_stb),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .mosi_s      (mosi_s),
    .cs_active   (cs_active)
  );

  spi_bit_counter i_bit_counter (
    .clk        (clk),
    .arst_n     (arst_n),
    .sample_stb (sample_stb),
    .clear      (cnt_clear),
    .last_bit   (last_bit)
  );

  // Partial word drop is already folded into cnt_clear
  spi_frame_fsm i_frame_fsm (
    .clk         (clk),
    .arst_n      (arst_n),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .sample_stb  (sample_stb),
    .last_bit    (last_bit),
    .cnt_clear   (cnt_clear),
    .load_tx     (load_tx),
    .word_done   (word_done),
    .first_word  (first_word),
    .discard     ()
  );

  spi_shift_reg i_shift_reg (
    .clk        (clk),
    .arst_n     (arst_n),
    .sample_stb (sample_stb),
    .shift_stb  (shift_stb),
    .mosi_s     (mosi_s),
    .load_tx    (load_tx),
    .tx_valid   (tx_valid),
    .tx_word    (tx_held),
    .cs_active  (cs_active),
    .rx_word    (rx_word),
    .miso       (miso)
  );

  // Receive entry, the endpoint requests and the local side answers
  spi_word_hold #(.payload_t(rx_entry_t)) i_rx_hold (
    .clk            (clk),
    .arst_n         (arst_n),
    .role_is_source (1'b1),
    .wr_stb         (word_done),
    .wr_data        ({rx_word, first_word}),
    .rd_stb         (1'b0),
    .req            (rx_req),
    .ack            (rx_ack),
    .data           ({rx_data, rx_first}),
    .full           (),
    .overrun        (overrun)
  );

  // Response entry, the local side requests and the endpoint answers
  // Consumed by the next response load in the shift register
  spi_word_hold #(.payload_t(word_t)) i_tx_hold (
    .clk            (clk),
    .arst_n         (arst_n),
    .role_is_source (1'b0),
    .wr_stb         (1'b0),
    .wr_data        (tx_data),
    .rd_stb         (load_tx),
    .req            (tx_ack),
    .ack            (tx_req),
    .data           (tx_held),
    .full           (tx_valid),
    .overrun        ()
  );

endmodule

// ==== tests/spi_slave_tb.sv ====
/*
 * SPI slave endpoint testbench
 * Drives the SPI pins as a host in the package clock mode, answers the
 * receive handshake, preloads response words and checks each table row
 */
`timescale 1ns/10ps

module spi_slave_tb import spi_slave_pkg::*; ();

  localparam int CLK_NS      = 8;
  localparam int HALF_NS     = 40;
  localparam int HALF_CLKS   = HALF_NS / CLK_NS;
  localparam int NUM_TESTS   = 5;
  localparam int MAX_WORDS   = 3;
  localparam int HS_TIMEOUT  = 400;
  localparam int SETTLE_CLKS = 40;

  logic  clk;
  logic  arst_n;
  logic  sclk;
  logic  cs_n;
  logic  mosi;
  logic  miso;
  word_t rx_data;
  logic  rx_first;
  logic  rx_req;
  logic  rx_ack;
  word_t tx_data;
  logic  tx_req;
  logic  tx_ack;
  logic  overrun;

  // ******************************
  // Stimulus table
  // ******************************

  string t_name       [NUM_TESTS];
  int    t_nwords     [NUM_TESTS];
  word_t t_mosi       [NUM_TESTS][MAX_WORDS];
  logic  t_preload    [NUM_TESTS];
  word_t t_tx_word    [NUM_TESTS];
  logic  t_hold_ack   [NUM_TESTS];
  // Index of the word cut short by cs, -1 when the frame runs to the end
  int    t_abort_at   [NUM_TESTS];
  int    t_exp_rx_cnt [NUM_TESTS];
  word_t t_exp_rx     [NUM_TESTS][MAX_WORDS];
  logic  t_exp_first  [NUM_TESTS][MAX_WORDS];
  word_t t_exp_miso   [NUM_TESTS][MAX_WORDS];
  logic  t_exp_ovr    [NUM_TESTS];
  int    num_rows;
  logic  table_ready;

  // Entries taken by the local-side responder, in arrival order
  word_t rx_q [$];
  logic  first_q [$];
  logic  hold_ack;
  // Words the host read back on miso in the current frame
  word_t got_miso [MAX_WORDS];
  int    got_miso_cnt;
  int    errors;
  int    tests_run;
  int    tests_failed;
  int    seed;
  int    seed_dummy;

  spi_slave_top i_dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .miso     (miso),
    .rx_data  (rx_data),
    .rx_first (rx_first),
    .rx_req   (rx_req),
    .rx_ack   (rx_ack),
    .tx_data  (tx_data),
    .tx_req   (tx_req),
    .tx_ack   (tx_ack),
    .overrun  (overrun)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  task automatic begin_row(input string name, input logic preload, input word_t tx_word,
                           input logic hold, input int abort_at, input logic exp_ovr);
    t_name[num_rows]       = name;
    t_nwords[num_rows]     = 0;
    t_preload[num_rows]    = preload;
    t_tx_word[num_rows]    = tx_word;
    t_hold_ack[num_rows]   = hold;
    t_abort_at[num_rows]   = abort_at;
    t_exp_rx_cnt[num_rows] = 0;
    t_exp_ovr[num_rows]    = exp_ovr;
    num_rows = num_rows + 1;
  endtask

  // One MOSI word and the response expected on miso during it
  task automatic add_word(input word_t mosi_word, input word_t exp_miso);
    int r;
    r = num_rows - 1;
    t_mosi[r][t_nwords[r]]     = mosi_word;
    t_exp_miso[r][t_nwords[r]] = exp_miso;
    t_nwords[r] = t_nwords[r] + 1;
  endtask

  task automatic expect_rx(input word_t data, input logic first);
    int r;
    r = num_rows - 1;
    t_exp_rx[r][t_exp_rx_cnt[r]]    = data;
    t_exp_first[r][t_exp_rx_cnt[r]] = first;
    t_exp_rx_cnt[r] = t_exp_rx_cnt[r] + 1;
  endtask

  task automatic build_table();
    num_rows = 0;
    begin_row("single_word", 1'b0, '0, 1'b0, -1, 1'b0);
    add_word(16'hA55A, SPI_DEFAULT_MISO);
    expect_rx(16'hA55A, 1'b1);
    begin_row("preload_one", 1'b1, 16'h5AA5, 1'b0, -1, 1'b0);
    add_word(16'h1234, 16'h5AA5);
    expect_rx(16'h1234, 1'b1);
    // Preload goes out in word one only, the rest fall back to the default
    begin_row("three_words", 1'b1, 16'hBEEF, 1'b0, -1, 1'b0);
    add_word(16'h0F0F, 16'hBEEF);
    add_word(16'hF00F, SPI_DEFAULT_MISO);
    add_word(16'h8001, SPI_DEFAULT_MISO);
    expect_rx(16'h0F0F, 1'b1);
    expect_rx(16'hF00F, 1'b0);
    expect_rx(16'h8001, 1'b0);
    // cs rises halfway through word two
    begin_row("cs_early", 1'b1, 16'h7E81, 1'b0, 1, 1'b0);
    add_word(16'h1357, 16'h7E81);
    add_word(16'h2468, SPI_DEFAULT_MISO);
    expect_rx(16'h1357, 1'b1);
    // Overrun is sticky, so this row stays last
    begin_row("overrun", 1'b0, '0, 1'b1, -1, 1'b1);
    add_word(16'hC3C3, SPI_DEFAULT_MISO);
    add_word(16'h3C3C, SPI_DEFAULT_MISO);
    expect_rx(16'hC3C3, 1'b1);
  endtask

  function automatic int total_frame_ns();
    int sum;
    sum = 0;
    for (int t = 0; t < num_rows; t++) begin
      sum = sum + (t_nwords[t] * SPI_WORD_W * 2 + 4) * HALF_NS;
    end
    return sum;
  endfunction

  // ******************************
  // Host and local side
  // ******************************

  task automatic wait_clks(input int n);
    repeat (n) @(negedge clk);
  endtask

  // One cs frame, sclk edges follow SPI_CPOL and SPI_CPHA
  task automatic run_frame(input int t);
    int    nw;
    int    bits;
    word_t miso_bits;
    nw = (t_abort_at[t] >= 0) ? t_abort_at[t] + 1 : t_nwords[t];
    got_miso_cnt = 0;
    @(negedge clk);
    sclk = SPI_CPOL;
    cs_n = 1'b0;
    for (int w = 0; w < nw; w++) begin
      bits = (w == t_abort_at[t]) ? SPI_WORD_W / 2 : SPI_WORD_W;
      miso_bits = '0;
      for (int b = SPI_WORD_W - 1; b >= SPI_WORD_W - bits; b--) begin
        if (!SPI_CPHA) begin
          // Data leads the sampling edge by half a period
          mosi = t_mosi[t][w][b];
          wait_clks(HALF_CLKS);
          miso_bits = {miso_bits[SPI_WORD_W-2:0], miso};
          sclk = ~SPI_CPOL;
          wait_clks(HALF_CLKS);
          sclk = SPI_CPOL;
        end else begin
          sclk = ~SPI_CPOL;
          mosi = t_mosi[t][w][b];
          wait_clks(HALF_CLKS);
          miso_bits = {miso_bits[SPI_WORD_W-2:0], miso};
          sclk = SPI_CPOL;
          wait_clks(HALF_CLKS);
        end
      end
      if (bits == SPI_WORD_W) begin
        got_miso[got_miso_cnt] = miso_bits;
        got_miso_cnt = got_miso_cnt + 1;
      end
    end
    wait_clks(HALF_CLKS);
    cs_n = 1'b1;
    // Gap lets the last word_done and any overrun settle
    wait_clks(2 * HALF_CLKS);
  endtask

  // Local side loads a response word over the tx handshake
  task automatic preload_tx(input word_t w, output bit ok);
    int n;
    ok = 1'b1;
    @(negedge clk);
    tx_data = w;
    tx_req  = 1'b1;
    n = 0;
    while (!tx_ack && n < HS_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    ok = tx_ack;
    tx_req = 1'b0;
    n = 0;
    while (tx_ack && n < HS_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (tx_ack) ok = 1'b0;
  endtask

  // Local-side receiver with a random ack delay, stalled while hold_ack is set
  initial begin : rx_responder
    int delay;
    forever begin
      @(negedge clk);
      if (arst_n && rx_req && !rx_ack) begin
        delay = $urandom % 4;
        repeat (delay) @(negedge clk);
        while (hold_ack) @(negedge clk);
        rx_q.push_back(rx_data);
        first_q.push_back(rx_first);
        rx_ack = 1'b1;
        while (rx_req) @(negedge clk);
        rx_ack = 1'b0;
      end
    end
  end

  // ******************************
  // Checks per row
  // ******************************

  task automatic run_test(input int t);
    int fails;
    int n;
    bit ok;
    fails = 0;
    rx_q.delete();
    first_q.delete();
    hold_ack = t_hold_ack[t];
    if (t_preload[t]) begin
      preload_tx(t_tx_word[t], ok);
      if (!ok) begin
        $display("Test %s: tx_ack handshake did not complete in time", t_name[t]);
        fails++;
      end
    end
    run_frame(t);
    if (t_hold_ack[t]) begin
      // Entry held under back-pressure must still be the first word
      if (rx_req !== 1'b1) begin
        $display("Error %s: held rx_req expected 1 actual %b", t_name[t], rx_req);
        fails++;
      end
      if (rx_data !== t_exp_rx[t][0]) begin
        $display("Error %s: held rx_data expected %h actual %h",
                 t_name[t], t_exp_rx[t][0], rx_data);
        fails++;
      end
      if (rx_first !== t_exp_first[t][0]) begin
        $display("Error %s: held rx_first expected %b actual %b",
                 t_name[t], t_exp_first[t][0], rx_first);
        fails++;
      end
      hold_ack = 1'b0;
    end
    n = 0;
    while (rx_q.size() < t_exp_rx_cnt[t] && n < HS_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    wait_clks(SETTLE_CLKS);
    if (rx_q.size() != t_exp_rx_cnt[t]) begin
      $display("Error %s: rx entry count expected %0d actual %0d",
               t_name[t], t_exp_rx_cnt[t], rx_q.size());
      fails++;
    end
    for (int i = 0; i < t_exp_rx_cnt[t] && i < rx_q.size(); i++) begin
      if (rx_q[i] !== t_exp_rx[t][i]) begin
        $display("Error %s: rx word %0d expected %h actual %h",
                 t_name[t], i, t_exp_rx[t][i], rx_q[i]);
        fails++;
      end
      if (first_q[i] !== t_exp_first[t][i]) begin
        $display("Error %s: rx_first of word %0d expected %b actual %b",
                 t_name[t], i, t_exp_first[t][i], first_q[i]);
        fails++;
      end
    end
    for (int i = 0; i < got_miso_cnt; i++) begin
      if (got_miso[i] !== t_exp_miso[t][i]) begin
        $display("Error %s: miso word %0d expected %h actual %h",
                 t_name[t], i, t_exp_miso[t][i], got_miso[i]);
        fails++;
      end
    end
    if (overrun !== t_exp_ovr[t]) begin
      $display("Error %s: overrun expected %b actual %b", t_name[t], t_exp_ovr[t], overrun);
      fails++;
    end
    tests_run++;
    if (fails != 0) tests_failed++;
    errors = errors + fails;
    $display("Test %-12s %s, %0d mismatches", t_name[t], (fails == 0) ? "passed" : "failed",
             fails);
  endtask

  // ******************************
  // Sequence and watchdog
  // ******************************

  initial begin : watchdog
    int limit_ns;
    wait (table_ready);
    limit_ns = 2 * total_frame_ns() + 20000;
    #(limit_ns);
    $display("Timeout: the run was still busy after %0d ns", limit_ns);
    $display("Finished with errors");
    $finish;
  end

  initial begin : main
    int fails;
    arst_n      = 1'b0;
    sclk        = SPI_CPOL;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    rx_ack      = 1'b0;
    tx_data     = '0;
    tx_req      = 1'b0;
    hold_ack    = 1'b0;
    errors      = 0;
    tests_run   = 0;
    tests_failed = 0;
    table_ready = 1'b0;
    seed        = 58;
    seed_dummy  = $urandom(seed);
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    // Idle outputs straight after reset
    fails = 0;
    if (rx_req !== 1'b0) begin
      $display("Error reset_state: rx_req expected 0 actual %b", rx_req);
      fails++;
    end
    if (tx_ack !== 1'b0) begin
      $display("Error reset_state: tx_ack expected 0 actual %b", tx_ack);
      fails++;
    end
    if (overrun !== 1'b0) begin
      $display("Error reset_state: overrun expected 0 actual %b", overrun);
      fails++;
    end
    if (miso !== 1'b0) begin
      $display("Error reset_state: miso expected 0 actual %b", miso);
      fails++;
    end
    tests_run++;
    if (fails != 0) tests_failed++;
    errors = errors + fails;
    $display("Test %-12s %s, %0d mismatches", "reset_state",
             (fails == 0) ? "passed" : "failed", fails);
    for (int t = 0; t < num_rows; t++) begin
      run_test(t);
    end
    $display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
rtl/spi_slave_pkg.sv
rtl/spi_pin_sync.sv
rtl/spi_bit_counter.sv
rtl/spi_frame_fsm.sv
rtl/spi_shift_reg.sv
rtl/spi_word_hold.sv
rtl/spi_slave_top.sv
tests/spi_slave_tb.sv
